//--- board_io_pkg.sv
`default_nettype none

package board_io_pkg;

    // ***********************************************************
    // Sequencer states and TM1638 command opcodes.
    // ***********************************************************

    typedef enum logic [2:0]
    {
        st_idle,
        st_mode_cmd,
        st_addr_cmd,
        st_data,
        st_disp_cmd,
        st_read_cmd,
        st_read_data,
        st_gap
    } seq_state_e;

    typedef enum logic [7:0]
    {
        cmd_write_auto = 8'h40,
        cmd_read_keys  = 8'h42,
        cmd_addr0      = 8'hC0,
        cmd_disp_on    = 8'h8F
    } tm_cmd_e;

    // ***********************************************************
    // Byte shifter request and response, microphone sample.
    // ***********************************************************

    typedef struct packed
    {
        logic       start;
        logic       read;
        logic [7:0] tx_byte;
    } serdes_req_t;

    typedef struct packed
    {
        logic       done;
        logic       busy;
        logic [7:0] rx_byte;
    } serdes_rsp_t;

    typedef struct packed
    {
        logic               valid;
        logic signed [23:0] value;
    } mic_sample_t;

    localparam int          n_digits    = 8;
    localparam int          n_key_bytes = 4;
    localparam logic [11:0] mic_offset  = 12'h800;

endpackage

`default_nettype wire

//--- board_io_seq.sv
`timescale 1ns/1ps
`default_nettype none

module board_io_seq
#(
    parameter sio_half   = 50,
    parameter mic_period = 2000
)
(
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire board_io_pkg::serdes_rsp_t  rsp,
    input  wire  [7:0]                      buf_byte,
    input  wire                             rx_busy,
    output board_io_pkg::serdes_req_t       req,
    output logic                            sio_stb,
    output wire  [3:0]                      byte_idx,
    output logic                            key_wr,
    output logic [1:0]                      key_idx,
    output logic                            mic_start
);

    localparam gw = $clog2(sio_half + 16) + 1;
    localparam mw = $clog2(mic_period) + 1;

    board_io_pkg::seq_state_e state_q;
    board_io_pkg::seq_state_e next_q;

    logic [gw - 1:0] gap_q;
    logic [3:0]      cnt_q;
    logic            issued_q;
    logic            start_q;
    logic            read_q;
    logic [7:0]      tx_q;
    logic [mw - 1:0] mic_cnt_q;

    logic [7:0]      cur_tx;
    logic            cur_read;
    logic            xfer;
    wire             issue = xfer && !issued_q && !rsp.busy;

    // Byte for the current transfer state.
    always_comb
    begin
        cur_tx   = 8'h00;
        cur_read = 1'b0;
        xfer     = 1'b1;
        case (state_q)
            board_io_pkg::st_mode_cmd:  cur_tx   = board_io_pkg::cmd_write_auto;
            board_io_pkg::st_addr_cmd:  cur_tx   = board_io_pkg::cmd_addr0;
            board_io_pkg::st_data:      cur_tx   = buf_byte;
            board_io_pkg::st_disp_cmd:  cur_tx   = board_io_pkg::cmd_disp_on;
            board_io_pkg::st_read_cmd:  cur_tx   = board_io_pkg::cmd_read_keys;
            board_io_pkg::st_read_data: cur_read = 1'b1;
            default:                    xfer     = 1'b0;
        endcase
    end

    // ***********************************************************
    // Frame FSM.
    // ***********************************************************

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q  <= board_io_pkg::st_idle;
            next_q   <= board_io_pkg::st_mode_cmd;
            gap_q    <= '0;
            cnt_q    <= '0;
            issued_q <= 1'b0;
            start_q  <= 1'b0;
            read_q   <= 1'b0;
            sio_stb  <= 1'b1;
            key_wr   <= 1'b0;
            key_idx  <= '0;
        end
        else
        begin
            start_q <= 1'b0;
            key_wr  <= 1'b0;

            if (issue)
            begin
                start_q  <= 1'b1;
                issued_q <= 1'b1;
                read_q   <= cur_read;
            end

            case (state_q)
                board_io_pkg::st_idle,
                board_io_pkg::st_gap:
                begin
                    // Startup wait is 16 cycles, group gaps are sio_half.
                    if (gap_q == (state_q == board_io_pkg::st_idle ? gw'(15)
                                                                   : gw'(sio_half - 1)))
                    begin
                        gap_q    <= '0;
                        sio_stb  <= 1'b0;
                        issued_q <= 1'b0;
                        state_q  <= next_q;
                    end
                    else
                        gap_q <= gap_q + 1'b1;
                end

                board_io_pkg::st_addr_cmd,
                board_io_pkg::st_read_cmd:
                begin
                    // Strobe stays low, data bytes follow.
                    if (rsp.done)
                    begin
                        cnt_q    <= '0;
                        issued_q <= 1'b0;
                        state_q  <= (state_q == board_io_pkg::st_addr_cmd)
                                  ? board_io_pkg::st_data : board_io_pkg::st_read_data;
                    end
                end

                board_io_pkg::st_data,
                board_io_pkg::st_read_data:
                begin
                    if (rsp.done)
                    begin
                        if (state_q == board_io_pkg::st_read_data)
                        begin
                            key_wr  <= 1'b1;
                            key_idx <= cnt_q[1:0];
                        end

                        if (state_q == board_io_pkg::st_data ? cnt_q == 4'd15
                            : cnt_q == 4'(board_io_pkg::n_key_bytes - 1))
                        begin
                            sio_stb <= 1'b1;
                            state_q <= board_io_pkg::st_gap;
                            next_q  <= (state_q == board_io_pkg::st_data)
                                     ? board_io_pkg::st_disp_cmd : board_io_pkg::st_mode_cmd;
                        end
                        else
                        begin
                            cnt_q    <= cnt_q + 1'b1;
                            issued_q <= 1'b0;
                        end
                    end
                end

                default:
                begin
                    // Single-byte groups end with a gap.
                    if (rsp.done)
                    begin
                        sio_stb <= 1'b1;
                        state_q <= board_io_pkg::st_gap;
                        next_q  <= (state_q == board_io_pkg::st_mode_cmd)
                                 ? board_io_pkg::st_addr_cmd : board_io_pkg::st_read_cmd;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (issue)
            tx_q <= cur_tx;
    end

    // Microphone request pacing.
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mic_cnt_q <= '0;
            mic_start <= 1'b0;
        end
        else if (mic_cnt_q == mw'(mic_period - 1))
        begin
            mic_cnt_q <= '0;
            mic_start <= !rx_busy;
        end
        else
        begin
            mic_cnt_q <= mic_cnt_q + 1'b1;
            mic_start <= 1'b0;
        end
    end

    assign req      = '{start: start_q, read: read_q, tx_byte: tx_q};
    assign byte_idx = cnt_q;

    a_start_ok: assert property (@(posedge clk) disable iff (!rst_n)
        req.start |-> !rsp.busy && !sio_stb);

endmodule

`default_nettype wire

//--- tm1638_serdes.sv
`timescale 1ns/1ps
`default_nettype none

module tm1638_serdes
#(
    parameter sio_half = 50
)
(
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire board_io_pkg::serdes_req_t  req,
    input  wire                             sio_din,
    output board_io_pkg::serdes_rsp_t       rsp,
    output logic                            sio_clk,
    output wire                             sio_dout,
    output logic                            sio_oe
);

    localparam cw = $clog2(sio_half) + 1;

    logic [cw - 1:0] cnt_q;
    logic [3:0]      ph_q;      // Half-bit phase, even is clock low.
    logic [7:0]      shift_q;
    logic            busy_q;
    logic            done_q;
    logic            read_q;

    wire half_end = (cnt_q == cw'(sio_half - 1));

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            cnt_q   <= '0;
            ph_q    <= '0;
            busy_q  <= 1'b0;
            done_q  <= 1'b0;
            read_q  <= 1'b0;
            sio_clk <= 1'b1;
            sio_oe  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (!busy_q)
            begin
                if (req.start)
                begin
                    busy_q  <= 1'b1;
                    read_q  <= req.read;
                    sio_oe  <= !req.read;
                    sio_clk <= 1'b0;
                    cnt_q   <= '0;
                    ph_q    <= '0;
                end
            end
            else if (half_end)
            begin
                cnt_q <= '0;
                ph_q  <= ph_q + 1'b1;
                if (!ph_q[0])
                    sio_clk <= 1'b1;
                else if (ph_q == 4'd15)
                begin
                    // Clock already high, release the line.
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                    sio_oe <= 1'b0;
                end
                else
                    sio_clk <= 1'b0;
            end
            else
                cnt_q <= cnt_q + 1'b1;
        end
    end

    // Write shifts on falling edges, read collects on rising edges.
    always_ff @(posedge clk)
    begin
        if (!busy_q && req.start)
            shift_q <= req.tx_byte;
        else if (busy_q && half_end)
        begin
            if (!ph_q[0] && read_q)
                shift_q <= {sio_din, shift_q[7:1]};
            else if (ph_q[0] && !read_q && ph_q != 4'd15)
                shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    assign sio_dout = shift_q[0];
    assign rsp      = '{done: done_q, busy: busy_q, rx_byte: shift_q};

    a_oe_stable: assert property (@(posedge clk) disable iff (!rst_n)
        busy_q && $past(busy_q) |-> $stable(sio_oe));

endmodule

`default_nettype wire

//--- tm1638_frame_buf.sv
`timescale 1ns/1ps
`default_nettype none

module tm1638_frame_buf
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire  [7:0] abcdefgh,
    input  wire  [7:0] digit,
    input  wire  [7:0] led,
    input  wire  [3:0] byte_idx,
    input  wire        key_wr,
    input  wire  [1:0] key_idx,
    input  wire  [7:0] rx_byte,
    output logic [7:0] buf_byte,
    output logic [7:0] keys
);

    logic [7:0] seg_q [board_io_pkg::n_digits];
    logic [7:0] hgfedcba;
    logic [7:0] shadow_q;
    logic [7:0] shadow_d;

    wire last_key = (key_idx == 2'(board_io_pkg::n_key_bytes - 1));

    // ***********************************************************
    // Display image.
    // ***********************************************************

    always_comb
    begin
        for (int i = 0; i < 8; i++)
            hgfedcba[i] = abcdefgh[7 - i];
    end

    // Each digit keeps its last value while it is selected.
    always_ff @(posedge clk)
    begin
        for (int i = 0; i < board_io_pkg::n_digits; i++)
        begin
            if (digit[i])
                seg_q[i] <= hgfedcba;
        end
    end

    // Even address holds segments, odd address holds the LED.
    always_comb
    begin
        if (byte_idx[0])
            buf_byte = {7'b0, led[byte_idx[3:1]]};
        else
            buf_byte = seg_q[byte_idx[3:1]];
    end

    // ***********************************************************
    // Key bytes.
    // ***********************************************************

    always_comb
    begin
        shadow_d                  = shadow_q;
        shadow_d[{1'b0, key_idx}] = rx_byte[0];
        shadow_d[{1'b1, key_idx}] = rx_byte[4];
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            shadow_q <= '0;
            keys     <= '0;
        end
        else if (key_wr)
        begin
            shadow_q <= shadow_d;
            if (last_key)
                keys <= shadow_d;   // All eight keys change at once.
        end
    end

endmodule

`default_nettype wire

//--- mic3_spi_rx.sv
`timescale 1ns/1ps
`default_nettype none

module mic3_spi_rx
#(
    parameter sck_half = 4
)
(
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        start,
    input  wire                        mic_sdo,
    output logic                       busy,
    output logic                       mic_cs,
    output logic                       mic_sck,
    output board_io_pkg::mic_sample_t  mic
);

    localparam cw = $clog2(sck_half) + 1;

    logic [cw - 1:0]    cnt_q;
    logic [4:0]         ph_q;
    logic [11:0]        shift_q;   // Leading zero bits fall off the top.
    logic               fin_q;
    logic               valid_q;
    logic signed [23:0] value_q;
    logic [11:0]        diff;

    wire half_end = (cnt_q == cw'(sck_half - 1));

    assign diff = shift_q - board_io_pkg::mic_offset;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy    <= 1'b0;
            mic_cs  <= 1'b1;
            mic_sck <= 1'b1;
            cnt_q   <= '0;
            ph_q    <= '0;
            fin_q   <= 1'b0;
            valid_q <= 1'b0;
        end
        else
        begin
            valid_q <= 1'b0;
            fin_q   <= 1'b0;
            if (fin_q)
            begin
                busy    <= 1'b0;
                valid_q <= 1'b1;
            end
            else if (!busy)
            begin
                if (start)
                begin
                    busy   <= 1'b1;
                    mic_cs <= 1'b0;
                    cnt_q  <= '0;
                    ph_q   <= '0;
                end
            end
            else if (half_end)
            begin
                cnt_q <= '0;
                ph_q  <= ph_q + 1'b1;
                if (!ph_q[0])
                    mic_sck <= 1'b0;
                else
                begin
                    mic_sck <= 1'b1;
                    if (ph_q == 5'd31)
                    begin
                        mic_cs <= 1'b1;
                        fin_q  <= 1'b1;
                    end
                end
            end
            else
                cnt_q <= cnt_q + 1'b1;
        end
    end

    // Sample on rising sck, MSB first.
    always_ff @(posedge clk)
    begin
        if (busy && !mic_cs && half_end && ph_q[0])
            shift_q <= {shift_q[10:0], mic_sdo};
        if (fin_q)
            value_q <= {{12{diff[11]}}, diff};
    end

    assign mic = '{valid: valid_q, value: value_q};

    a_sck_in_cs: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(mic_sck) |-> !$past(mic_cs));

endmodule

`default_nettype wire

//--- board_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_io_top
#(
    parameter clk_mhz    = 50,
    parameter sio_half   = (clk_mhz + 1) / 2,
    parameter sck_half   = (clk_mhz + 7) / 8,
    parameter mic_period = clk_mhz * 20
)
(
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire  [7:0]                      abcdefgh,
    input  wire  [7:0]                      digit,
    input  wire  [7:0]                      led,
    output wire  [7:0]                      keys,
    output wire                             sio_clk,
    output wire                             sio_stb,
    output wire                             sio_dout,
    output wire                             sio_oe,
    input  wire                             sio_din,
    output wire                             mic_cs,
    output wire                             mic_sck,
    input  wire                             mic_sdo,
    output wire board_io_pkg::mic_sample_t  mic
);

    board_io_pkg::serdes_req_t req;
    board_io_pkg::serdes_rsp_t rsp;

    wire [7:0] buf_byte;
    wire [3:0] byte_idx;
    wire       key_wr;
    wire [1:0] key_idx;
    wire       mic_start;
    wire       rx_busy;

    board_io_seq
    #(
        .sio_half   ( sio_half   ),
        .mic_period ( mic_period )
    )
    u_seq
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .rsp        ( rsp        ),
        .buf_byte   ( buf_byte   ),
        .rx_busy    ( rx_busy    ),
        .req        ( req        ),
        .sio_stb    ( sio_stb    ),
        .byte_idx   ( byte_idx   ),
        .key_wr     ( key_wr     ),
        .key_idx    ( key_idx    ),
        .mic_start  ( mic_start  )
    );

    tm1638_serdes
    #(
        .sio_half   ( sio_half   )
    )
    u_serdes
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .req        ( req        ),
        .sio_din    ( sio_din    ),
        .rsp        ( rsp        ),
        .sio_clk    ( sio_clk    ),
        .sio_dout   ( sio_dout   ),
        .sio_oe     ( sio_oe     )
    );

    tm1638_frame_buf u_frame_buf
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .abcdefgh   ( abcdefgh   ),
        .digit      ( digit      ),
        .led        ( led        ),
        .byte_idx   ( byte_idx   ),
        .key_wr     ( key_wr     ),
        .key_idx    ( key_idx    ),
        .rx_byte    ( rsp.rx_byte ),
        .buf_byte   ( buf_byte   ),
        .keys       ( keys       )
    );

    mic3_spi_rx
    #(
        .sck_half   ( sck_half   )
    )
    u_mic
    (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .start      ( mic_start  ),
        .mic_sdo    ( mic_sdo    ),
        .busy       ( rx_busy    ),
        .mic_cs     ( mic_cs     ),
        .mic_sck    ( mic_sck    ),
        .mic        ( mic        )
    );

endmodule

`default_nettype wire

//--- tb_board_io_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_board_io_top;

    localparam int sio_half     = 2;
    localparam int sck_half     = 2;
    localparam int mic_period   = 200;
    // One frame is 24 bytes of 16 half periods, with start overhead and four gaps.
    localparam int frame_cycles = 24 * (16 * sio_half + 4) + 4 * (sio_half + 2);
    localparam int cycle_limit  = 32 + 6 * frame_cycles + 5 * mic_period;

    logic       clk;
    logic       rst_n;
    logic [7:0] abcdefgh;
    logic [7:0] digit;
    logic [7:0] led;
    logic       sio_din = 1'b0;
    logic       mic_sdo = 1'b0;
    wire  [7:0] keys;
    wire        sio_clk;
    wire        sio_stb;
    wire        sio_dout;
    wire        sio_oe;
    wire        mic_cs;
    wire        mic_sck;
    wire board_io_pkg::mic_sample_t mic;

    logic [7:0]  seg_img [8];
    logic [7:0]  led_img;
    logic [7:0]  key_state;
    logic [7:0]  keys_prev;
    logic [11:0] adc_sample;
    int          cycles = 0;

    // TM1638 and ADC model state.
    logic [7:0]  tm_shift;
    int          tm_bits;
    int          rd_bit;
    logic        prev_sclk;
    logic        prev_stb;
    logic [7:0]  cur_grp [$];
    logic [7:0]  last_grp [$];
    int          grp_cnt = 0;
    logic [15:0] adc_shift;

    board_io_top
    #(
        .sio_half   ( sio_half   ),
        .sck_half   ( sck_half   ),
        .mic_period ( mic_period )
    )
    u_board_io_top
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    ),
        .led      ( led      ),
        .keys     ( keys     ),
        .sio_clk  ( sio_clk  ),
        .sio_stb  ( sio_stb  ),
        .sio_dout ( sio_dout ),
        .sio_oe   ( sio_oe   ),
        .sio_din  ( sio_din  ),
        .mic_cs   ( mic_cs   ),
        .mic_sck  ( mic_sck  ),
        .mic_sdo  ( mic_sdo  ),
        .mic      ( mic      )
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ***********************************************************
    // Behavioural models.
    // ***********************************************************

    function automatic logic key_bit(input int r);
        int j;
        int b;
        j = r / 8;
        b = r % 8;
        if (j > 3)
            return 1'b0;
        if (b == 0)
            return key_state[j];
        if (b == 4)
            return key_state[j + 4];
        return 1'b0;
    endfunction

    // TM1638 chip, looked at 1 ns after each clock edge.
    always @(posedge clk)
    begin
        #1;
        if (!rst_n)
        begin
            prev_sclk = 1'b1;
            prev_stb  = 1'b1;
            tm_bits   = 0;
            rd_bit    = 0;
        end
        else
        begin
            if (prev_stb && !sio_stb)
            begin
                tm_bits = 0;
                rd_bit  = 0;
                cur_grp.delete();
            end
            if (!prev_sclk && sio_clk && !sio_stb)
            begin
                tm_shift = {(sio_oe ? sio_dout : sio_din), tm_shift[7:1]};
                tm_bits++;
                if (tm_bits == 8)
                begin
                    cur_grp.push_back(tm_shift);
                    tm_bits = 0;
                end
            end
            if (prev_sclk && !sio_clk && !sio_stb && !sio_oe)
            begin
                sio_din = key_bit(rd_bit);
                rd_bit++;
            end
            if (!prev_stb && sio_stb && cur_grp.size() > 0)
            begin
                last_grp = cur_grp;
                cur_grp.delete();
                grp_cnt++;
            end
            prev_sclk = sio_clk;
            prev_stb  = sio_stb;
        end
    end

    // ADC loads on chip select, then shifts MSB first on falling sck.
    always @(negedge mic_cs or negedge mic_sck)
    begin
        #2;
        if (!mic_cs && mic_sck)
            adc_shift = {4'h0, adc_sample};
        else if (!mic_cs)
        begin
            mic_sdo   = adc_shift[15];
            adc_shift = {adc_shift[14:0], 1'b0};
        end
    end

    // ***********************************************************
    // Checks and helpers.
    // ***********************************************************

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp)
            fail_run($sformatf("ERR %0t %s expected %b got %b", $time, name, exp, act));
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            fail_run($sformatf("ERR %0t %s expected %h got %h", $time, name, exp, act));
    endtask

    task automatic check_keys(input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
            fail_run($sformatf("ERR %0t keys expected %h got %h", $time, exp, act));
    endtask

    task automatic check_mic(input logic signed [23:0] exp, input logic signed [23:0] act);
        if (act !== exp)
            fail_run($sformatf("ERR %0t mic.value expected %0d got %0d", $time, exp, act));
    endtask

    function automatic logic [7:0] reverse_bits(input logic [7:0] x);
        logic [7:0] r;
        for (int b = 0; b < 8; b++)
            r[7 - b] = x[b];
        return r;
    endfunction

    function automatic logic signed [23:0] expected_mic(input logic [11:0] s);
        int d;
        d = int'(s) - 2048;
        return d[23:0];
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_next_group();
        int n;
        n = grp_cnt;
        while (grp_cnt == n)
            next_cycle();
    endtask

    task automatic wait_mic_valid();
        next_cycle();
        while (!mic.valid)
            next_cycle();
    endtask

    task automatic check_idle_levels();
        check_level("sio_stb", 1'b1, sio_stb);
        check_level("sio_clk", 1'b1, sio_clk);
        check_level("mic_cs", 1'b1, mic_cs);
        check_level("sio_oe", 1'b0, sio_oe);
        check_level("mic.valid", 1'b0, mic.valid);
        check_keys(8'h00, keys);
    endtask

    // Shows each digit in turn, the way a multiplexed lab display does.
    task automatic apply_image();
        for (int i = 0; i < 8; i++)
        begin
            digit    = 8'(1 << i);
            abcdefgh = seg_img[i];
            next_cycle();
        end
        digit    = 8'h00;
        abcdefgh = 8'($urandom);
        led      = led_img;
    endtask

    // ***********************************************************
    // Directed tests.
    // ***********************************************************

    task automatic test_reset_levels();
        check_idle_levels();
        apply_image();
        repeat (4) next_cycle();
        rst_n = 1'b1;
        next_cycle();
        check_idle_levels();
    endtask

    // Group order, display bytes and key readback of one full frame.
    task automatic test_frame_content();
        logic [7:0] exp;
        wait_next_group();
        check_byte("mode group size", 8'd1, 8'(last_grp.size()));
        check_byte("mode command", 8'h40, last_grp[0]);
        wait_next_group();
        check_byte("data group size", 8'd17, 8'(last_grp.size()));
        check_byte("address command", 8'hC0, last_grp[0]);
        for (int i = 0; i < 8; i++)
        begin
            check_byte($sformatf("data byte %0d", 2 * i), reverse_bits(seg_img[i]),
                       last_grp[1 + 2 * i]);
            check_byte($sformatf("data byte %0d", 2 * i + 1), {7'b0, led_img[i]},
                       last_grp[2 + 2 * i]);
        end
        wait_next_group();
        check_byte("display group size", 8'd1, 8'(last_grp.size()));
        check_byte("display command", 8'h8F, last_grp[0]);
        wait_next_group();
        check_byte("read group size", 8'd5, 8'(last_grp.size()));
        check_byte("read command", 8'h42, last_grp[0]);
        for (int j = 0; j < 4; j++)
        begin
            exp = {3'b0, key_state[j + 4], 3'b0, key_state[j]};
            check_byte($sformatf("key byte %0d", j), exp, last_grp[1 + j]);
        end
        // Keys move one cycle after the strobe rises.
        check_keys(keys_prev, keys);
        next_cycle();
        check_keys(key_state, keys);
        keys_prev = key_state;
    endtask

    task automatic test_frame_update();
        seg_img[3] = seg_img[3] ^ (8'($urandom) | 8'h01);
        led_img    = ~led_img;
        key_state  = 8'($urandom);
        digit      = 8'h08;
        abcdefgh   = seg_img[3];
        led        = led_img;
        next_cycle();
        digit      = 8'h00;
        abcdefgh   = 8'($urandom);
        test_frame_content();
    endtask

    task automatic test_mic_samples();
        logic [11:0] samples [4];
        samples[0] = 12'h000;
        samples[1] = 12'h800;
        samples[2] = 12'hFFF;
        samples[3] = 12'($urandom);
        // Line up with the transfer schedule first.
        wait_mic_valid();
        for (int k = 0; k < 4; k++)
        begin
            adc_sample = samples[k];
            wait_mic_valid();
            check_mic(expected_mic(samples[k]), mic.value);
            next_cycle();
            check_level("mic.valid", 1'b0, mic.valid);
            check_mic(expected_mic(samples[k]), mic.value);
        end
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles == cycle_limit)
            fail_run($sformatf("Timeout after %0d cycles, the tests did not complete", cycles));
    end

    initial
    begin
        void'($urandom(32'h30e73e5b));
        rst_n      = 1'b0;
        abcdefgh   = 8'h00;
        digit      = 8'h00;
        led        = 8'h00;
        keys_prev  = 8'h00;
        key_state  = 8'($urandom);
        adc_sample = 12'($urandom);
        led_img    = 8'($urandom);
        for (int i = 0; i < 8; i++)
            seg_img[i] = 8'($urandom);
        repeat (4) next_cycle();

        test_reset_levels();
        test_frame_content();
        test_frame_update();
        test_mic_samples();

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- board_io_top.f
board_io_pkg.sv
board_io_seq.sv
tm1638_serdes.sv
tm1638_frame_buf.sv
mic3_spi_rx.sv
board_io_top.sv
tb_board_io_top.sv

//--- Makefile
# Verilator build for the board I/O subsystem.

VERILATOR  ?= verilator
FLIST      ?= board_io_top.f
RTL_TOP    ?= board_io_top
TB_TOP     ?= tb_board_io_top
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --timing
SIM_FLAGS  ?= --binary --assert -j 0
PASS_MSG   ?= Finished with no errors

SIM_EXE := $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

$(SIM_EXE): $(shell cat $(FLIST))
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o V$(TB_TOP)

sim: $(SIM_EXE)
	@out="$$(./$(SIM_EXE) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
